//--- design/addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module addr_decoder (
  // Read port request
  input  bank_mem_pkg::byte_addr_t                                         rd_addr_i,
  input  logic                                                             rd_valid_i,
  output logic                                                             rd_ready_o,
  // Write port request
  input  bank_mem_pkg::wr_req_t                                            wr_req_i,
  input  logic                                                             wr_valid_i,
  output logic                                                             wr_ready_o,
  // Per port, per bank readiness from the arbiters
  input  logic [bank_mem_pkg::NumPorts-1:0][bank_mem_pkg::NumBanks-1:0]    bank_ready_i,
  // Per port request toward the arbiters
  output bank_mem_pkg::bank_req_t [bank_mem_pkg::NumPorts-1:0]             port_req_o,
  output logic [bank_mem_pkg::NumPorts-1:0][bank_mem_pkg::NumBanks-1:0]    bank_valid_o,
  // Accept strobe and its bank, for the response path
  output logic [bank_mem_pkg::NumPorts-1:0]                                accept_o,
  output bank_mem_pkg::bank_sel_t [bank_mem_pkg::NumPorts-1:0]             accept_sel_o
);
  import bank_mem_pkg::*;

  // Both ports gathered into arrays indexed by port
  byte_addr_t [NumPorts-1:0] port_addr;
  data_t      [NumPorts-1:0] port_wdata;
  strb_t      [NumPorts-1:0] port_wstrb;
  logic       [NumPorts-1:0] port_valid;
  logic       [NumPorts-1:0] port_ready;

  // Read port carries no write data
  assign port_addr[PortRd]  = rd_addr_i;
  assign port_wdata[PortRd] = '0;
  assign port_wstrb[PortRd] = '0;
  assign port_valid[PortRd] = rd_valid_i;

  assign port_addr[PortWr]  = wr_req_i.addr;
  assign port_wdata[PortWr] = wr_req_i.wdata;
  assign port_wstrb[PortWr] = wr_req_i.wstrb;
  assign port_valid[PortWr] = wr_valid_i;

  assign rd_ready_o = port_ready[PortRd];
  assign wr_ready_o = port_ready[PortWr];

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    bank_sel_t sel;
    word_addr_t word_addr;

    // Low bits above the byte offset pick the bank
    assign sel = port_addr[p][BankSelOffset +: BankSelWidth];
    // Everything above the select is the word address inside the bank
    assign word_addr = port_addr[p][BankSelOffset + BankSelWidth +: WordAddrWidth];

    // Write enable follows the port identity
    assign port_req_o[p] = bank_req_t'{
      addr:  word_addr,
      we:    (p == PortWr),
      wdata: port_wdata[p],
      wstrb: port_wstrb[p]
    };

    // One-hot valid toward the selected bank only
    assign bank_valid_o[p] = {{(NumBanks-1){1'b0}}, port_valid[p]} << sel;

    // Port ready is the ready of the bank it points at
    assign port_ready[p] = bank_ready_i[p][sel];

    // Handshake on this port, reported with its bank
    assign accept_o[p]     = port_valid[p] & port_ready[p];
    assign accept_sel_o[p] = sel;
  end

endmodule

`default_nettype wire

//--- design/bank_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n_i,
  // Requests from both ports toward this bank
  input  bank_mem_pkg::bank_req_t [bank_mem_pkg::NumPorts-1:0]  req_i,
  input  logic [bank_mem_pkg::NumPorts-1:0]                     valid_i,
  output logic [bank_mem_pkg::NumPorts-1:0]                     ready_o,
  // Bank side
  output bank_mem_pkg::bank_req_t                               mem_req_o,
  output logic                                                  mem_valid_o,
  input  logic                                                  mem_ready_i
);
  import bank_mem_pkg::*;

  // Port that wins the next contention
  port_e prio_q;
  // Grant held while the bank stalls a request
  logic  lock_q;
  port_e lock_port_q;
  // Port granted this cycle
  port_e grant;

  logic contend;
  logic stall;
  logic xfer;

  assign contend = &valid_i;

  always_comb begin
    if (lock_q) begin
      // Keep the stalled request on the bank, payload must not change
      grant = lock_port_q;
    end else if (contend) begin
      grant = prio_q;
    end else if (valid_i[PortWr]) begin
      grant = PortWr;
    end else begin
      // Read port by default, also covers the idle case
      grant = PortRd;
    end
  end

  // Bank sees the granted port only
  assign mem_req_o   = req_i[grant];
  assign mem_valid_o = valid_i[grant];

  // Only the granted port gets the bank ready
  always_comb begin
    ready_o        = '0;
    ready_o[grant] = mem_ready_i;
  end

  assign stall = mem_valid_o & ~mem_ready_i;
  assign xfer  = mem_valid_o & mem_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q      <= PortRd;
      lock_q      <= 1'b0;
      lock_port_q <= PortRd;
    end else begin
      // Lock as long as the bank holds the request off
      lock_q <= stall;
      if (stall) begin
        lock_port_q <= grant;
      end
      // Round robin: winner of a contended transfer yields next time
      if (xfer && contend) begin
        prio_q <= (grant == PortRd) ? PortWr : PortRd;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/bank_mem_pkg.sv
`default_nettype none

package bank_mem_pkg;

  // Two request ports, index 0 reads and index 1 writes
  localparam int unsigned NumPorts = 2;

  // Number of memory banks, power of two so the select has no holes
  localparam int unsigned NumBanks = 4;

  // Memory word and byte enable sizes
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Byte offset inside a word sits below the bank select
  localparam int unsigned BankSelOffset = $clog2(StrbWidth);
  localparam int unsigned BankSelWidth  = $clog2(NumBanks);

  // Word address inside a single bank
  localparam int unsigned WordAddrWidth = 10;

  // Full port byte address, offset then bank select then word address
  localparam int unsigned AddrWidth = BankSelOffset + BankSelWidth + WordAddrWidth;

  // Read latency of one bank in cycles, at least 1
  localparam int unsigned MemLatency = 2;

  typedef logic [AddrWidth-1:0]     byte_addr_t;
  typedef logic [WordAddrWidth-1:0] word_addr_t;
  typedef logic [BankSelWidth-1:0]  bank_sel_t;
  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [StrbWidth-1:0]     strb_t;

  // Write port payload
  typedef struct packed {
    byte_addr_t addr;
    data_t      wdata;
    strb_t      wstrb;
  } wr_req_t;

  // Request as a bank sees it
  typedef struct packed {
    // Word address inside the bank
    word_addr_t addr;
    // High for writes
    logic       we;
    data_t      wdata;
    // Byte enables, only meaningful when we is set
    strb_t      wstrb;
  } bank_req_t;

  // Arbiter priority, names the port that wins the next contention
  typedef enum logic {
    PortRd = 1'b0,
    PortWr = 1'b1
  } port_e;

endpackage

`default_nettype wire

//--- design/bank_mem_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module bank_mem_xbar (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n_i,
  // Read port
  input  bank_mem_pkg::byte_addr_t                              rd_addr_i,
  input  logic                                                  rd_valid_i,
  output logic                                                  rd_ready_o,
  output logic                                                  rd_rsp_valid_o,
  output bank_mem_pkg::data_t                                   rd_rdata_o,
  // Write port
  input  bank_mem_pkg::wr_req_t                                 wr_req_i,
  input  logic                                                  wr_valid_i,
  output logic                                                  wr_ready_o,
  output logic                                                  wr_rsp_valid_o,
  // Memory banks
  output bank_mem_pkg::bank_req_t [bank_mem_pkg::NumBanks-1:0]  mem_req_o,
  output logic [bank_mem_pkg::NumBanks-1:0]                     mem_valid_o,
  input  logic [bank_mem_pkg::NumBanks-1:0]                     mem_ready_i,
  input  bank_mem_pkg::data_t [bank_mem_pkg::NumBanks-1:0]      mem_rdata_i
);
  import bank_mem_pkg::*;

  // Decoder side, indexed port first
  bank_req_t [NumPorts-1:0]                port_req;
  logic      [NumPorts-1:0][NumBanks-1:0]  port_bank_valid;
  logic      [NumPorts-1:0][NumBanks-1:0]  port_bank_ready;

  // Arbiter side, indexed bank first
  logic      [NumBanks-1:0][NumPorts-1:0]  bank_port_valid;
  logic      [NumBanks-1:0][NumPorts-1:0]  bank_port_ready;

  // Accepts for the response path
  logic      [NumPorts-1:0]                accept;
  bank_sel_t [NumPorts-1:0]                accept_sel;

  // Address split and port readiness
  addr_decoder i_addr_decoder (
    .rd_addr_i    ( rd_addr_i       ),
    .rd_valid_i   ( rd_valid_i      ),
    .rd_ready_o   ( rd_ready_o      ),
    .wr_req_i     ( wr_req_i        ),
    .wr_valid_i   ( wr_valid_i      ),
    .wr_ready_o   ( wr_ready_o      ),
    .bank_ready_i ( port_bank_ready ),
    .port_req_o   ( port_req        ),
    .bank_valid_o ( port_bank_valid ),
    .accept_o     ( accept          ),
    .accept_sel_o ( accept_sel      )
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    // Transpose valids into the arbiter and readies back out
    for (genvar p = 0; p < NumPorts; p++) begin : gen_port
      assign bank_port_valid[b][p] = port_bank_valid[p][b];
      assign port_bank_ready[p][b] = bank_port_ready[b][p];
    end

    // Every arbiter sees both port payloads, valids differ per bank
    bank_arbiter i_bank_arbiter (
      .clk_i       ( clk_i              ),
      .arst_n_i    ( arst_n_i           ),
      .req_i       ( port_req           ),
      .valid_i     ( bank_port_valid[b] ),
      .ready_o     ( bank_port_ready[b] ),
      .mem_req_o   ( mem_req_o[b]       ),
      .mem_valid_o ( mem_valid_o[b]     ),
      .mem_ready_i ( mem_ready_i[b]     )
    );
  end

  // Fixed latency return of read data and write acks
  rsp_router i_rsp_router (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .accept_i       ( accept         ),
    .accept_sel_i   ( accept_sel     ),
    .mem_rdata_i    ( mem_rdata_i    ),
    .rd_rsp_valid_o ( rd_rsp_valid_o ),
    .rd_rdata_o     ( rd_rdata_o     ),
    .wr_rsp_valid_o ( wr_rsp_valid_o )
  );

endmodule

`default_nettype wire

//--- design/rsp_router.sv
`timescale 1ns/1ps
`default_nettype none

module rsp_router (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n_i,
  // Accepted requests per port and the bank they went to
  input  logic [bank_mem_pkg::NumPorts-1:0]                     accept_i,
  input  bank_mem_pkg::bank_sel_t [bank_mem_pkg::NumPorts-1:0]  accept_sel_i,
  // Read data of every bank
  input  bank_mem_pkg::data_t [bank_mem_pkg::NumBanks-1:0]      mem_rdata_i,
  // Read response
  output logic                                                  rd_rsp_valid_o,
  output bank_mem_pkg::data_t                                   rd_rdata_o,
  // Write acknowledge
  output logic                                                  wr_rsp_valid_o
);
  import bank_mem_pkg::*;

  // One pipeline entry, a request in flight and its bank
  typedef struct packed {
    logic      valid;
    bank_sel_t sel;
  } rsp_tag_t;

  // Stage 0 is the newest, stage MemLatency-1 lines up with the bank data
  rsp_tag_t [NumPorts-1:0][MemLatency-1:0] tag_q;
  rsp_tag_t [NumPorts-1:0]                 tag_out;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tag_q <= '0;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        // New entry every cycle, valid only on an accept
        tag_q[p][0] <= rsp_tag_t'{valid: accept_i[p], sel: accept_sel_i[p]};
        for (int s = 1; s < MemLatency; s++) begin
          tag_q[p][s] <= tag_q[p][s-1];
        end
      end
    end
  end

  // Oldest stage of each port
  for (genvar p = 0; p < NumPorts; p++) begin : gen_tap
    assign tag_out[p] = tag_q[p][MemLatency-1];
  end

  // Read data comes from the bank the read went to
  assign rd_rsp_valid_o = tag_out[PortRd].valid;
  assign rd_rdata_o     = mem_rdata_i[tag_out[PortRd].sel];

  // Writes only need the acknowledge
  assign wr_rsp_valid_o = tag_out[PortWr].valid;

endmodule

`default_nettype wire

//--- flist.f
design/bank_mem_pkg.sv
design/addr_decoder.sv
design/bank_arbiter.sv
design/rsp_router.sv
design/bank_mem_xbar.sv
verif/sram_bank_model.sv
verif/tb_bank_mem_xbar.sv

//--- verif/sram_bank_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank_model #(
  parameter int unsigned BankIdx = 0
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  bank_mem_pkg::bank_req_t req_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  output bank_mem_pkg::data_t     rdata_o
);
  import bank_mem_pkg::*;

  data_t       mem [2**WordAddrWidth];
  // Read data on its way out, last stage drives rdata_o
  data_t       rd_pipe [MemLatency];
  logic [31:0] rnd_q;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Power-up contents, a hash of the full word-aligned byte address
  initial begin
    for (int w = 0; w < 2**WordAddrWidth; w++) begin
      mem[w] = (32'({w[WordAddrWidth-1:0], bank_sel_t'(BankIdx), 2'b00}) * 32'h9e37_79b1)
               ^ 32'h5bd1_e995;
    end
  end

  // Ready is random, high about three cycles in four
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // Each bank starts its own stream
      rnd_q   <= 32'h87a8_24d9 ^ (BankIdx * 32'h0001_0001);
      ready_o <= 1'b0;
    end else begin
      rnd_q   <= xorshift32(rnd_q);
      ready_o <= |rnd_q[1:0];
    end
  end

  always @(posedge clk_i) begin
    // Byte lanes only where the strobe is set
    if (valid_i && ready_o && req_i.we) begin
      for (int i = 0; i < StrbWidth; i++) begin
        if (req_i.wstrb[i]) begin
          mem[req_i.addr][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
    rd_pipe[0] <= (valid_i && ready_o && !req_i.we) ? mem[req_i.addr] : '0;
    for (int s = 1; s < MemLatency; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  assign rdata_o = rd_pipe[MemLatency-1];

endmodule

`default_nettype wire

//--- verif/tb_bank_mem_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bank_mem_xbar;
  import bank_mem_pkg::*;

  // Cycles a single wait may take before the run is abandoned
  localparam int unsigned WaitLimit = 500;

  logic       clk_i;
  logic       arst_n_i;
  byte_addr_t rd_addr_i;
  logic       rd_valid_i;
  logic       rd_ready_o;
  logic       rd_rsp_valid_o;
  data_t      rd_rdata_o;
  wr_req_t    wr_req_i;
  logic       wr_valid_i;
  logic       wr_ready_o;
  logic       wr_rsp_valid_o;

  bank_req_t [NumBanks-1:0] mem_req_o;
  logic      [NumBanks-1:0] mem_valid_o;
  logic      [NumBanks-1:0] mem_ready_i;
  data_t     [NumBanks-1:0] mem_rdata_i;

  // Reference image with one entry per byte address
  logic [7:0]  ref_mem [2**AddrWidth];
  int unsigned errors;
  int unsigned rd_issued;
  int unsigned wr_issued;
  int unsigned rd_done;
  int unsigned wr_acked;

  // Port handshakes and the fields the banks must see
  logic       rd_hs;
  logic       wr_hs;
  bank_sel_t  rd_sel;
  bank_sel_t  wr_sel;
  word_addr_t rd_word;
  bank_req_t  exp_wr_req;

  // Handshake history where bit MemLatency-1 lines up with the response
  logic [MemLatency-1:0]    rd_hs_q;
  logic [MemLatency-1:0]    wr_hs_q;
  data_t                    exp_rdata_q [MemLatency];
  bank_req_t [NumBanks-1:0] prev_req_q;
  logic      [NumBanks-1:0] prev_stall_q;
  // Transfers of the other port on the bank a waiting port points at
  int unsigned              rd_wait_q;
  int unsigned              wr_wait_q;

  always #2 clk_i = ~clk_i;

  bank_mem_xbar i_bank_mem_xbar (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .rd_addr_i      ( rd_addr_i      ),
    .rd_valid_i     ( rd_valid_i     ),
    .rd_ready_o     ( rd_ready_o     ),
    .rd_rsp_valid_o ( rd_rsp_valid_o ),
    .rd_rdata_o     ( rd_rdata_o     ),
    .wr_req_i       ( wr_req_i       ),
    .wr_valid_i     ( wr_valid_i     ),
    .wr_ready_o     ( wr_ready_o     ),
    .wr_rsp_valid_o ( wr_rsp_valid_o ),
    .mem_req_o      ( mem_req_o      ),
    .mem_valid_o    ( mem_valid_o    ),
    .mem_ready_i    ( mem_ready_i    ),
    .mem_rdata_i    ( mem_rdata_i    )
  );

  // Byte address bits 3:2 pick the bank and bits 13:4 the word inside it
  assign rd_hs      = rd_valid_i & rd_ready_o;
  assign wr_hs      = wr_valid_i & wr_ready_o;
  assign rd_sel     = rd_addr_i[3:2];
  assign wr_sel     = wr_req_i.addr[3:2];
  assign rd_word    = rd_addr_i[13:4];
  assign exp_wr_req = bank_req_t'{
    addr:  wr_req_i.addr[13:4],
    we:    1'b1,
    wdata: wr_req_i.wdata,
    wstrb: wr_req_i.wstrb
  };

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    sram_bank_model #(.BankIdx(b)) i_sram_bank_model (
      .clk_i    ( clk_i          ),
      .arst_n_i ( arst_n_i       ),
      .req_i    ( mem_req_o[b]   ),
      .valid_i  ( mem_valid_o[b] ),
      .ready_o  ( mem_ready_i[b] ),
      .rdata_o  ( mem_rdata_i[b] )
    );

    // A bank transfer belongs to a handshake of the matching port
    a_src: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (mem_valid_o[b] && mem_ready_i[b]) |->
        ((rd_hs && rd_sel == b && !mem_req_o[b].we) ||
         (wr_hs && wr_sel == b && mem_req_o[b].we)))
    else begin
      errors++;
      $display("error %0t: bank %0d transfer matches no port handshake", $time, b);
    end

    // Stalled request keeps valid and payload
    a_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      prev_stall_q[b] |-> (mem_valid_o[b] && mem_req_o[b] == prev_req_q[b]))
    else begin
      errors++;
      $display("error %0t: mem_req_o[%0d] expected %h valid 1 actual %h valid %b", $time, b,
               $sampled(prev_req_q[b]), $sampled(mem_req_o[b]), $sampled(mem_valid_o[b]));
    end
  end

  function automatic data_t fill_word(input byte_addr_t addr);
    return (32'(addr) * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  function automatic data_t ref_word(input byte_addr_t addr);
    data_t w;
    for (int i = 0; i < StrbWidth; i++) begin
      w[8*i +: 8] = ref_mem[{addr[13:2], 2'(i)}];
    end
    return w;
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_hs_q      <= '0;
      wr_hs_q      <= '0;
      prev_stall_q <= '0;
      prev_req_q   <= '0;
      rd_wait_q    <= 0;
      wr_wait_q    <= 0;
      rd_done      <= 0;
      wr_acked     <= 0;
    end else begin
      rd_hs_q      <= (rd_hs_q << 1) | MemLatency'(rd_hs);
      wr_hs_q      <= (wr_hs_q << 1) | MemLatency'(wr_hs);
      prev_stall_q <= mem_valid_o & ~mem_ready_i;
      prev_req_q   <= mem_req_o;
      if (!rd_valid_i || rd_hs) begin
        rd_wait_q <= 0;
      end else if (wr_hs && wr_sel == rd_sel) begin
        rd_wait_q <= rd_wait_q + 1;
      end
      if (!wr_valid_i || wr_hs) begin
        wr_wait_q <= 0;
      end else if (rd_hs && rd_sel == wr_sel) begin
        wr_wait_q <= wr_wait_q + 1;
      end
      rd_done  <= rd_done + 32'(rd_rsp_valid_o);
      wr_acked <= wr_acked + 32'(wr_rsp_valid_o);
    end
  end

  // Expected read word taken from the reference at the handshake
  always @(posedge clk_i) begin
    exp_rdata_q[0] <= rd_hs ? ref_word(rd_addr_i) : '0;
    for (int s = 1; s < MemLatency; s++) begin
      exp_rdata_q[s] <= exp_rdata_q[s-1];
    end
  end

  a_rd_lat: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rd_rsp_valid_o == rd_hs_q[MemLatency-1])
  else begin
    errors++;
    $display("error %0t: rd_rsp_valid_o expected %b actual %b", $time,
             $sampled(rd_hs_q[MemLatency-1]), $sampled(rd_rsp_valid_o));
  end

  a_wr_lat: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wr_rsp_valid_o == wr_hs_q[MemLatency-1])
  else begin
    errors++;
    $display("error %0t: wr_rsp_valid_o expected %b actual %b", $time,
             $sampled(wr_hs_q[MemLatency-1]), $sampled(wr_rsp_valid_o));
  end

  a_rdata: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rd_rsp_valid_o |-> rd_rdata_o == exp_rdata_q[MemLatency-1])
  else begin
    errors++;
    $display("error %0t: rd_rdata_o expected %h actual %h", $time,
             $sampled(exp_rdata_q[MemLatency-1]), $sampled(rd_rdata_o));
  end

  a_rd_map: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rd_hs |-> (mem_valid_o[rd_sel] && mem_ready_i[rd_sel] &&
               mem_req_o[rd_sel].addr == rd_word && !mem_req_o[rd_sel].we))
  else begin
    errors++;
    $display("error %0t: mem_req_o[%0d] expected addr %h we 0 actual addr %h we %b", $time,
             $sampled(rd_sel), $sampled(rd_word), $sampled(mem_req_o[rd_sel].addr),
             $sampled(mem_req_o[rd_sel].we));
  end

  a_wr_map: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wr_hs |-> (mem_valid_o[wr_sel] && mem_ready_i[wr_sel] && mem_req_o[wr_sel] == exp_wr_req))
  else begin
    errors++;
    $display("error %0t: mem_req_o[%0d] expected %h actual %h", $time, $sampled(wr_sel),
             $sampled(exp_wr_req), $sampled(mem_req_o[wr_sel]));
  end

  // Own transfer plus at most one of the other port
  a_fair: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rd_wait_q <= 1 && wr_wait_q <= 1)
  else begin
    errors++;
    $display("error %0t: rd_wait_q/wr_wait_q expected at most 1 actual %0d/%0d", $time,
             $sampled(rd_wait_q), $sampled(wr_wait_q));
  end

  task automatic abort_run(input string why);
    $display("%0t: %s", $time, why);
    $display("errors: %0d", errors);
    $display("Result: FAILED");
    $finish;
  endtask

  task automatic write_bytes(input byte_addr_t addr, input data_t data, input strb_t strb);
    int unsigned waited;
    waited     = 0;
    wr_req_i   = wr_req_t'{addr: addr, wdata: data, wstrb: strb};
    wr_valid_i = 1'b1;
    @(negedge clk_i);
    while (!wr_ready_o && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
    end
    if (!wr_ready_o) begin
      abort_run("write request was never accepted");
    end else begin
      // Transfer happens on the coming edge so the reference takes the bytes now
      for (int i = 0; i < StrbWidth; i++) begin
        if (strb[i]) begin
          ref_mem[{addr[13:2], 2'(i)}] = data[8*i +: 8];
        end
      end
      wr_issued++;
      @(posedge clk_i);
      #0.5;
      wr_valid_i = 1'b0;
    end
  endtask

  task automatic read_back(input byte_addr_t addr);
    int unsigned waited;
    waited     = 0;
    rd_addr_i  = addr;
    rd_valid_i = 1'b1;
    @(negedge clk_i);
    while (!rd_ready_o && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
    end
    if (!rd_ready_o) begin
      abort_run("read request was never accepted");
    end else begin
      rd_issued++;
      @(posedge clk_i);
      #0.5;
      rd_valid_i = 1'b0;
    end
  endtask

  task automatic drain_writes();
    int unsigned waited;
    waited = 0;
    while (wr_acked != wr_issued && waited < WaitLimit) begin
      @(posedge clk_i);
      #0.5;
      waited++;
    end
    if (wr_acked != wr_issued) begin
      abort_run("write acknowledges are missing");
    end
  endtask

  task automatic await_reads();
    int unsigned waited;
    waited = 0;
    while (rd_done != rd_issued && waited < WaitLimit) begin
      @(posedge clk_i);
      #0.5;
      waited++;
    end
    if (rd_done != rd_issued) begin
      abort_run("read responses are missing");
    end
  endtask

  initial begin
    data_t fill;
    clk_i      = 1'b0;
    arst_n_i   = 1'b0;
    rd_addr_i  = '0;
    rd_valid_i = 1'b0;
    wr_req_i   = '0;
    wr_valid_i = 1'b0;
    errors     = 0;
    rd_issued  = 0;
    wr_issued  = 0;
    for (int a = 0; a < 2**AddrWidth; a += StrbWidth) begin
      fill = fill_word(byte_addr_t'(a));
      for (int i = 0; i < StrbWidth; i++) begin
        ref_mem[a + i] = fill[8*i +: 8];
      end
    end
    repeat (4) @(posedge clk_i);
    #0.5;
    arst_n_i = 1'b1;

    // Full words across every bank and then read back to back
    for (int i = 0; i < 32; i++) begin
      write_bytes(byte_addr_t'(i * 4), {8'(i), 8'(~i), 8'(i * 3), 8'(i ^ 8'h5a)}, 4'hf);
    end
    drain_writes();
    for (int i = 0; i < 32; i++) begin
      read_back(byte_addr_t'(i * 4));
    end

    // Strobes 1 to 15 merge into the same words
    for (int i = 0; i < 32; i++) begin
      write_bytes(byte_addr_t'(i * 4), 32'h5a5a_5a5a ^ 32'(i * 32'h0102_0304),
                  strb_t'(i % 15 + 1));
    end
    drain_writes();
    for (int i = 0; i < 32; i++) begin
      read_back(byte_addr_t'(i * 4));
    end

    // Both ports on bank 2 every cycle while reads stay clear of the written words
    fork
      for (int i = 0; i < 24; i++) begin
        write_bytes({10'(64 + i), 2'd2, 2'b00}, 32'hc0de_0000 | 32'(i), 4'hf);
      end
      for (int i = 0; i < 24; i++) begin
        read_back({10'(i % 8), 2'd2, 2'b00});
      end
    join
    drain_writes();
    for (int i = 0; i < 24; i++) begin
      read_back({10'(64 + i), 2'd2, 2'b00});
    end
    await_reads();
    @(negedge clk_i);

    $display("errors: %0d, reads: %0d, writes: %0d", errors, rd_done, wr_acked);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
